// File: test/md_vectors.txt
// Columns are operator, signed mode, op_a, op_b and the expected result, in hex
// Operator 0 is MUL, 1 MULH, 2 DIV, 3 REM and mode bit 0 signs op_a, bit 1 signs op_b
0 0 00000007 00000006 0000002A
0 3 FFFFFFFD 00000005 FFFFFFF1
0 0 00010003 00020005 000B000F
0 1 FFFFFFFE 00000003 FFFFFFFA
1 0 00010003 00020005 00000002
1 0 FFFFFFFF FFFFFFFF FFFFFFFE
1 3 FFFFFFFF FFFFFFFF 00000000
1 1 FFFFFFFF FFFFFFFF FFFFFFFF
1 2 00000003 80000000 FFFFFFFE
1 1 80000000 80000000 C0000000
1 0 12345678 FFFFFFFF 12345677
2 0 00000064 00000007 0000000E
3 3 FFFFFF9C 00000007 FFFFFFFE
2 3 00000064 FFFFFFF9 FFFFFFF2
3 3 FFFFFF9C FFFFFFF9 FFFFFFFE
2 3 80000000 FFFFFFFF 80000000
3 3 80000000 FFFFFFFF 00000000
2 3 12345678 00000000 FFFFFFFF
3 0 87654321 00000000 87654321

// File: compile.f
logic/md_pkg.sv
logic/md_decode.sv
logic/md_mult.sv
logic/md_div.sv
logic/md_result.sv
logic/md_unit_top.sv
test/md_unit_checker.sv
test/md_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the multiply/divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module md_unit_tb -f compile.f -o md_unit_sim
./obj_dir/md_unit_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  exit 1
fi

// File: test/md_unit_tb.sv
// Multiply/divide unit testbench
// Replays the operation vectors under random ready stalls and checks every result

`timescale 1ns/10ps
`default_nettype none

module md_unit_tb;

  localparam int    CLK_PERIOD     = 10;
  localparam int    RST_CYCLES     = 8;
  localparam int    CYCLES_PER_VEC = 60;
  localparam string VEC_FILE       = "test/md_vectors.txt";

  // One line of the vector file
  typedef struct packed {
    logic [1:0]                op;
    logic [1:0]                mode;
    logic [md_pkg::XLEN-1:0]   a;
    logic [md_pkg::XLEN-1:0]   b;
    logic [md_pkg::XLEN-1:0]   expected;
  } vec_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    en_i;
  md_pkg::md_op_e          operator_i;
  logic [1:0]              signed_mode_i;
  logic [md_pkg::XLEN-1:0] op_a_i;
  logic [md_pkg::XLEN-1:0] op_b_i;
  logic                    ready_i;
  logic [md_pkg::XLEN-1:0] result_o;
  logic                    valid_o;

  vec_t vectors[$];
  int   seed = 54;
  int   errors;
  bit   loaded;

  md_unit_top DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Error %s expected %08h got %08h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_on_problem(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    vec_t        v;
    logic [31:0] op, mode, a, b, expected;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      stop_on_problem("Could not open the vector file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip blank lines and the column notes
        if (line.len() < 2 || line.substr(0, 1) == "//") continue;
        n = $sscanf(line, "%h %h %h %h %h", op, mode, a, b, expected);
        if (n != 5) stop_on_problem("A line of the vector file has the wrong format");
        v.op       = op[1:0];
        v.mode     = mode[1:0];
        v.a        = a;
        v.b        = b;
        v.expected = expected;
        vectors.push_back(v);
      end
      $fclose(fd);
      if (vectors.size() == 0) stop_on_problem("The vector file holds no operations");
    end
  endtask

  task automatic drive_op(input vec_t v);
    en_i          <= 1'b1;
    operator_i    <= md_pkg::md_op_e'(v.op);
    signed_mode_i <= v.mode;
    op_a_i        <= v.a;
    op_b_i        <= v.b;
  endtask

  // Returns at the falling edge before the edge that takes the result
  task automatic wait_result(input logic [md_pkg::XLEN-1:0] expected);
    logic first;
    logic taken;
    first = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      if (first) begin
        // Previous result is gone and the new one cannot be ready yet
        check_value("valid_o", 32'h0, 32'(valid_o));
        first = 1'b0;
      end else if (valid_o) begin
        check_value("result_o", expected, result_o);
        taken = ready_i;
      end
    end
  endtask

  // Consumer readiness is random after reset
  initial begin
    ready_i = 1'b0;
    wait (rst_ni);
    forever begin
      @(posedge clk_i);
      ready_i <= (($random(seed) & 3) != 0);
    end
  end

  initial begin
    wait (loaded);
    #(CLK_PERIOD * (RST_CYCLES + 2 + CYCLES_PER_VEC * (vectors.size() + 1)));
    $display("Timeout, the unit did not deliver all results in time");
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_ni        = 1'b0;
    en_i          = 1'b0;
    operator_i    = md_pkg::MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    errors        = 0;
    load_vectors();
    loaded = 1'b1;

    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (vectors[i]) begin
      @(posedge clk_i);
      drive_op(vectors[i]);
      wait_result(vectors[i].expected);
    end
    @(posedge clk_i);
    en_i <= 1'b0;
    // No further result may show up once the inputs go idle
    repeat (CYCLES_PER_VEC) begin
      @(negedge clk_i);
      check_value("valid_o", 32'h0, 32'(valid_o));
    end

    if (errors != 0) begin
      $display("=== FAIL ===");
      $fatal(1, "checks failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/md_unit_checker.sv
// Output protocol checker for the multiply/divide unit
// Bound into the top level to watch reset, the stalled result hold and idle engines

`timescale 1ns/10ps
`default_nettype none

module md_unit_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    valid_i,
  input logic                    ready_i,
  input logic [md_pkg::XLEN-1:0] result_i,
  input md_pkg::mult_state_e     mult_state_i,
  input md_pkg::div_state_e      div_state_i
);

  // Nothing valid while reset is held
  reset_valid_low: assert property (@(posedge clk_i) !rst_ni |-> !valid_i)
    else $error("valid_o high during reset");

  // Neither engine runs while a result is held
  held_engines_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> (mult_state_i == md_pkg::ALBL && div_state_i == md_pkg::DIV_IDLE))
    else $error("engine busy while a result is held");

  // A stalled result stays on the output unchanged
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (valid_i && !ready_i) |=> (valid_i && $stable(result_i)))
    else $error("result_o or valid_o changed while stalled");

endmodule

bind md_unit_top md_unit_checker u_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      (valid_o),
  .ready_i      (ready_i),
  .result_i     (result_o),
  .mult_state_i (u_mult.state_q),
  .div_state_i  (u_div.state_q)
);

`default_nettype wire

// File: logic/md_unit_top.sv
// Multiply/divide unit top level
// Decode feeds the multiply and divide engines, whose results meet in the result stage

`timescale 1ns/10ps
`default_nettype none

module md_unit_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en_i,
  input  md_pkg::md_op_e          operator_i,
  input  logic [1:0]              signed_mode_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  input  logic                    ready_i,
  output logic [md_pkg::XLEN-1:0] result_o,
  output logic                    valid_o
);

  md_pkg::md_ctrl_t ctrl;
  md_pkg::md_done_t mult_done;
  md_pkg::md_done_t div_done;
  logic             free;
  logic             mult_start;
  logic             div_start;

  // No new operation while a result is still held
  assign mult_start = en_i & free & ctrl.is_mult;
  assign div_start  = en_i & free & ~ctrl.is_mult;

  md_decode u_decode (
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ctrl_o        (ctrl)
  );

  md_mult u_mult (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (mult_start),
    .ctrl_i  (ctrl),
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .done_o  (mult_done)
  );

  md_div u_div (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (div_start),
    .ctrl_i  (ctrl),
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .done_o  (div_done)
  );

  md_result u_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mult_done_i (mult_done),
    .div_done_i  (div_done),
    .ready_i     (ready_i),
    .free_o      (free),
    .result_o    (result_o),
    .valid_o     (valid_o)
  );

endmodule

`default_nettype wire

// File: logic/md_result.sv
// Result stage
// One-entry register that holds a finished result until the consumer takes it

`timescale 1ns/10ps
`default_nettype none

module md_result (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  md_pkg::md_done_t        mult_done_i,
  input  md_pkg::md_done_t        div_done_i,
  input  logic                    ready_i,
  output logic                    free_o,
  output logic [md_pkg::XLEN-1:0] result_o,
  output logic                    valid_o
);

  logic                    full_q;
  logic [md_pkg::XLEN-1:0] data_q;
  logic                    capture;

  // Only one engine runs at a time
  assign capture = mult_done_i.done | div_done_i.done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (full_q && ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= mult_done_i.done ? mult_done_i.result : div_done_i.result;
    end
  end

  assign free_o   = ~full_q;
  assign valid_o  = full_q;
  assign result_o = data_q;

endmodule

`default_nettype wire

// File: logic/md_div.sv
// Divide engine
// Restoring long division, one quotient bit per cycle, signs fixed up at the end

`timescale 1ns/10ps
`default_nettype none

module md_div (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  md_pkg::md_ctrl_t        ctrl_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  output md_pkg::md_done_t        done_o
);

  md_pkg::div_state_e state_q, state_d;

  logic [md_pkg::XLEN-1:0]  rem_q, rem_d;
  logic [md_pkg::XLEN-1:0]  num_q, num_d;
  logic [md_pkg::XLEN-1:0]  den_q, den_d;
  logic [md_pkg::XLEN-1:0]  quot_q, quot_d;
  logic [md_pkg::CNT_W-1:0] cnt_q, cnt_d, cnt_dec;

  logic [md_pkg::XLEN-1:0]  sub_a, sub_b;
  logic [md_pkg::XLEN:0]    sub_res;
  logic                     ge;
  logic [md_pkg::XLEN-1:0]  one_shift;
  logic [md_pkg::XLEN-1:0]  next_rem, next_quot;
  logic                     neg_res;

  // Shared subtractor, the extra top bit is the borrow
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
  assign ge      = ~sub_res[md_pkg::XLEN];

  assign one_shift = {{(md_pkg::XLEN-1){1'b0}}, 1'b1} << cnt_q;
  assign cnt_dec   = cnt_q - 1'b1;
  assign next_rem  = ge ? sub_res[md_pkg::XLEN-1:0] : rem_q;
  assign next_quot = ge ? (quot_q | one_shift) : quot_q;

  // Quotient sign from both operands, remainder follows a
  assign neg_res = ctrl_i.want_quot ? ((ctrl_i.sign_a ^ ctrl_i.sign_b) & ~ctrl_i.b_zero)
                                    : ctrl_i.sign_a;

  always_comb begin
    state_d = state_q;
    rem_d   = rem_q;
    num_d   = num_q;
    den_d   = den_q;
    quot_d  = quot_q;
    cnt_d   = cnt_q;
    sub_a   = '0;
    sub_b   = op_a_i;

    unique case (state_q)
      md_pkg::DIV_IDLE: begin
        if (start_i) begin
          if (ctrl_i.b_zero) begin
            // Zero divisor: all ones for DIV, the dividend for REM
            rem_d   = ctrl_i.want_quot ? '1 : op_a_i;
            state_d = md_pkg::DIV_FINISH;
          end else begin
            state_d = md_pkg::DIV_ABS_A;
          end
        end
      end

      md_pkg::DIV_ABS_A: begin
        num_d   = ctrl_i.sign_a ? sub_res[md_pkg::XLEN-1:0] : op_a_i;
        quot_d  = '0;
        state_d = md_pkg::DIV_ABS_B;
      end

      md_pkg::DIV_ABS_B: begin
        sub_b   = op_b_i;
        den_d   = ctrl_i.sign_b ? sub_res[md_pkg::XLEN-1:0] : op_b_i;
        rem_d   = {{(md_pkg::XLEN-1){1'b0}}, num_q[md_pkg::XLEN-1]};
        cnt_d   = '1;
        state_d = md_pkg::DIV_COMP;
      end

      md_pkg::DIV_COMP: begin
        // Trial subtract, then shift in the next dividend bit
        sub_a  = rem_q;
        sub_b  = den_q;
        rem_d  = {next_rem[md_pkg::XLEN-2:0], num_q[cnt_dec]};
        quot_d = next_quot;
        cnt_d  = cnt_dec;
        if (cnt_q == 1) begin
          state_d = md_pkg::DIV_LAST;
        end
      end

      md_pkg::DIV_LAST: begin
        // Bit 0, keep only the word the operator asks for
        sub_a   = rem_q;
        sub_b   = den_q;
        rem_d   = ctrl_i.want_quot ? next_quot : next_rem;
        state_d = md_pkg::DIV_CHANGE_SIGN;
      end

      md_pkg::DIV_CHANGE_SIGN: begin
        sub_b   = rem_q;
        rem_d   = neg_res ? sub_res[md_pkg::XLEN-1:0] : rem_q;
        state_d = md_pkg::DIV_FINISH;
      end

      md_pkg::DIV_FINISH: begin
        state_d = md_pkg::DIV_IDLE;
      end

      default: begin
        state_d = md_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rem_q  <= rem_d;
    num_q  <= num_d;
    den_q  <= den_d;
    quot_q <= quot_d;
  end

  assign done_o.done   = (state_q == md_pkg::DIV_FINISH);
  assign done_o.result = rem_q;

endmodule

`default_nettype wire

// File: logic/md_mult.sv
// Multiply engine
// One 17x17 signed MAC with a 34-bit accumulator, MUL in 3 cycles, MULH in 4

`timescale 1ns/10ps
`default_nettype none

module md_mult (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  md_pkg::md_ctrl_t        ctrl_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  output md_pkg::md_done_t        done_o
);

  md_pkg::mult_state_e state_q, state_d;

  logic [md_pkg::HALF-1:0]          mac_a, mac_b;
  logic                             mac_sa, mac_sb;
  logic [2*md_pkg::HALF+1:0]        accum, accum_d, accum_q;
  logic signed [2*md_pkg::HALF+1:0] mac_res;
  logic [md_pkg::XLEN-1:0]          result_d, result_q;
  logic                             done_d, done_q;
  logic                             step;

  // Top bits of the sum always agree, so 34 bits hold it
  assign mac_res = $signed({mac_sa, mac_a}) * $signed({mac_sb, mac_b}) + $signed(accum);

  // Idle engine waits for a start, but not in the cycle its own done is out
  assign step = (state_q != md_pkg::ALBL) || (start_i && !done_q);

  always_comb begin
    mac_a    = op_a_i[md_pkg::HALF-1:0];
    mac_b    = op_b_i[md_pkg::HALF-1:0];
    mac_sa   = 1'b0;
    mac_sb   = 1'b0;
    accum    = '0;
    accum_d  = mac_res;
    state_d  = state_q;
    result_d = mac_res[md_pkg::XLEN-1:0];
    done_d   = 1'b0;

    unique case (state_q)
      md_pkg::ALBL: begin
        state_d = md_pkg::ALBH;
      end

      md_pkg::ALBH: begin
        // al*bh plus the upper half of al*bl
        mac_b  = op_b_i[md_pkg::XLEN-1:md_pkg::HALF];
        mac_sb = ctrl_i.sign_b;
        accum  = {{(md_pkg::HALF+2){1'b0}}, accum_q[md_pkg::XLEN-1:md_pkg::HALF]};
        if (!ctrl_i.want_high) begin
          accum_d = {2'b00, mac_res[md_pkg::HALF-1:0], accum_q[md_pkg::HALF-1:0]};
        end
        state_d = md_pkg::AHBL;
      end

      md_pkg::AHBL: begin
        mac_a  = op_a_i[md_pkg::XLEN-1:md_pkg::HALF];
        mac_sa = ctrl_i.sign_a;
        if (!ctrl_i.want_high) begin
          // Low word done: upper half from this step, lower half from al*bl
          accum    = {{(md_pkg::HALF+2){1'b0}}, accum_q[md_pkg::XLEN-1:md_pkg::HALF]};
          result_d = {mac_res[md_pkg::HALF-1:0], accum_q[md_pkg::HALF-1:0]};
          done_d   = 1'b1;
          state_d  = md_pkg::ALBL;
        end else begin
          accum   = accum_q;
          state_d = md_pkg::AHBH;
        end
      end

      md_pkg::AHBH: begin
        mac_a  = op_a_i[md_pkg::XLEN-1:md_pkg::HALF];
        mac_b  = op_b_i[md_pkg::XLEN-1:md_pkg::HALF];
        mac_sa = ctrl_i.sign_a;
        mac_sb = ctrl_i.sign_b;
        // Partial sum shifted down by 16, sign kept only for signed modes
        accum  = {{md_pkg::HALF{ctrl_i.any_signed & accum_q[2*md_pkg::HALF+1]}},
                  accum_q[2*md_pkg::HALF+1:md_pkg::HALF]};
        done_d  = 1'b1;
        state_d = md_pkg::ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::ALBL;
      done_q  <= 1'b0;
    end else begin
      done_q <= done_d;
      if (step) begin
        state_q <= state_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (step) begin
      accum_q <= accum_d;
    end
    if (done_d) begin
      result_q <= result_d;
    end
  end

  assign done_o.done   = done_q;
  assign done_o.result = result_q;

endmodule

`default_nettype wire

// File: logic/md_decode.sv
// Multiply/divide decode
// Classifies the operator and derives operand signs and the zero-divisor flag

`timescale 1ns/10ps
`default_nettype none

module md_decode (
  input  md_pkg::md_op_e          operator_i,
  input  logic [1:0]              signed_mode_i,
  input  logic [md_pkg::XLEN-1:0] op_a_i,
  input  logic [md_pkg::XLEN-1:0] op_b_i,
  output md_pkg::md_ctrl_t        ctrl_o
);

  always_comb begin
    ctrl_o.is_mult   = (operator_i == md_pkg::MD_OP_MULL) ||
                       (operator_i == md_pkg::MD_OP_MULH);
    ctrl_o.want_high = (operator_i == md_pkg::MD_OP_MULH);
    ctrl_o.want_quot = (operator_i == md_pkg::MD_OP_DIV);
    // Bit 0 of the mode qualifies a, bit 1 qualifies b
    ctrl_o.sign_a     = signed_mode_i[0] & op_a_i[md_pkg::XLEN-1];
    ctrl_o.sign_b     = signed_mode_i[1] & op_b_i[md_pkg::XLEN-1];
    ctrl_o.any_signed = (signed_mode_i != 2'b00);
    ctrl_o.b_zero     = (op_b_i == '0);
  end

endmodule

`default_nettype wire

// File: logic/md_pkg.sv
// Multiply and divide unit shared definitions
// Widths, operator and state encodings, and the structs passed between stages

`default_nettype none

package md_pkg;

  localparam int unsigned XLEN  = 32;
  localparam int unsigned HALF  = 16;
  localparam int unsigned CNT_W = 5;

  // Operator codes as used in the vector file
  typedef enum logic [1:0] {
    MD_OP_MULL = 2'd0,
    MD_OP_MULH = 2'd1,
    MD_OP_DIV  = 2'd2,
    MD_OP_REM  = 2'd3
  } md_op_e;

  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_CHANGE_SIGN, DIV_FINISH
  } div_state_e;

  // Decoded control, shared by both engines
  typedef struct packed {
    logic is_mult;
    logic want_high;
    logic want_quot;
    logic sign_a;
    logic sign_b;
    logic any_signed;
    logic b_zero;
  } md_ctrl_t;

  // Completion from an engine, done is a one-cycle pulse
  typedef struct packed {
    logic            done;
    logic [XLEN-1:0] result;
  } md_done_t;

endpackage

`default_nettype wire
